/* input_subsys.f */
hw/input_pkg.sv
hw/scan_timer.sv
hw/keypad_scan.sv
hw/digit_accum.sv
hw/input_fsm.sv
hw/input_apb_regs.sv
hw/input_top.sv
dv/keypad_model.sv
dv/input_tb.sv

/* dv/input_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module input_tb;

    localparam int SCAN_DIV       = 4;
    localparam int DEBOUNCE_SCANS = 2;
    localparam int SWITCH_CNT     = 16;
    localparam int HOLD_CYCLES    = 20 * 4 * SCAN_DIV;  // 20 full scans of four columns
    localparam int PRESS_CNT      = 40;                 // upper bound on key presses
    localparam int TIMEOUT_CYCLES = PRESS_CNT * 2 * HOLD_CYCLES + 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    input_pkg::reg_addr_t  paddr;
    input_pkg::data_t      pwdata;
    input_pkg::data_t      prdata;
    logic                  pready;
    logic                  pslverr;
    logic [3:0]            col;
    logic [3:0]            row;
    logic [SWITCH_CNT-1:0] switches;
    logic                  upload_done;
    logic                  cpu_pause;
    logic                  overflow;
    logic                  kp_press;
    input_pkg::key_code_t  kp_key;

    integer                seed = 32'h4db0_a5ab;
    int                    cycle_cnt = 0;
    input_pkg::data_t      exp_value;  // reference accumulator
    int                    exp_cnt;
    input_pkg::data_t      rd_data;
    logic                  rd_err;
    logic [SWITCH_CNT-1:0] sw_value;

    input_top #(
        .SCAN_DIV(SCAN_DIV), .DEBOUNCE_SCANS(DEBOUNCE_SCANS), .SWITCH_CNT(SWITCH_CNT)
    ) dut0 (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .col(col), .row(row), .switches(switches),
        .upload_done(upload_done), .cpu_pause(cpu_pause), .overflow(overflow)
    );

    keypad_model kp0 (.press(kp_press), .key(kp_key), .col(col), .row(row));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic apb_write(input input_pkg::reg_addr_t addr, input input_pkg::data_t data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;  // access phase, settled mid cycle
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input input_pkg::reg_addr_t addr, output input_pkg::data_t data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic press_key(input input_pkg::key_code_t key);
        @(posedge clk);
        kp_key   <= key;
        kp_press <= 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        kp_press <= 1'b0;
        repeat (HOLD_CYCLES) @(posedge clk);
    endtask

    task automatic enter_digit(input int d);
        press_key(input_pkg::key_code_t'(d));
        if (exp_cnt < 8) begin  // digits past the eighth are dropped
            exp_value = exp_value * 10 + d;
            exp_cnt   = exp_cnt + 1;
        end
    endtask

    task automatic erase_digit();
        press_key(input_pkg::key_back);
        if (exp_cnt > 0) begin
            exp_value = exp_value / 10;
            exp_cnt   = exp_cnt - 1;
        end
    endtask

    task automatic start_session();
        logic err;
        apb_write(input_pkg::ctrl_addr, 32'd1, err);
        expect_eq("session_request pslverr", 32'd0, err);
        repeat (4) @(posedge clk);  // request pulse, fsm and status snapshot
        exp_value = '0;
        exp_cnt   = 0;
    endtask

    task automatic check_status(input string name, input logic complete, input logic sw,
                                input logic paused);
        input_pkg::data_t exp;
        input_pkg::data_t act;
        logic             err;
        exp = {24'd0, exp_cnt[3:0], (exp_cnt == 8), paused, sw, complete};
        apb_read(input_pkg::status_addr, act, err);
        expect_eq({name, " pslverr"}, 32'd0, err);
        expect_eq(name, exp, act);
    endtask

    task automatic check_data(input string name, input input_pkg::data_t exp);
        input_pkg::data_t act;
        logic             err;
        apb_read(input_pkg::data_addr, act, err);
        expect_eq({name, " pslverr"}, 32'd0, err);
        expect_eq(name, exp, act);
    endtask

    a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else begin
            $display("FAIL apb_pready expected 1 actual %b", pready);
            abort_run();
        end

    a_pslverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> psel && penable)
        else begin
            $display("pslverr was raised outside an APB access phase");
            abort_run();
        end

    // all columns idle until the first step, then exactly one low for good
    a_col_one_low: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(~col) || (col == 4'hf && $past(col) == 4'hf))
        else begin
            $display("the keypad columns did not keep exactly one column low");
            abort_run();
        end

    initial begin
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        switches    = '0;
        upload_done = 1'b0;
        kp_press    = 1'b0;
        kp_key      = input_pkg::key_0;
        exp_value   = '0;
        exp_cnt     = 0;
        repeat (2) @(posedge clk);
        expect_eq("reset col", 32'hf, col);
        expect_eq("reset cpu_pause", 32'd0, cpu_pause);
        rst_n <= 1'b1;
        @(posedge clk);

        // decimal entry
        start_session();
        repeat (5) enter_digit($unsigned($random(seed)) % 10);
        press_key(input_pkg::key_enter);
        check_status("decimal_entry status", 1'b1, 1'b0, 1'b0);
        check_data("decimal_entry data", exp_value);

        // backspace, first on an empty value
        start_session();
        check_status("backspace session_start", 1'b0, 1'b0, 1'b0);
        erase_digit();
        check_data("backspace empty data", exp_value);
        check_status("backspace empty status", 1'b0, 1'b0, 1'b0);
        repeat (3) enter_digit($unsigned($random(seed)) % 10);
        repeat (2) erase_digit();
        enter_digit($unsigned($random(seed)) % 10);
        check_status("backspace status", 1'b0, 1'b0, 1'b0);
        check_data("backspace data", exp_value);
        press_key(input_pkg::key_enter);

        // overflow at eight digits
        start_session();
        repeat (10) enter_digit($unsigned($random(seed)) % 10);
        expect_eq("overflow pin", 32'd1, overflow);
        check_status("overflow status", 1'b0, 1'b0, 1'b0);
        check_data("overflow data", exp_value);
        press_key(input_pkg::key_enter);

        // switch mode
        start_session();
        sw_value = $random(seed);
        @(posedge clk);
        switches <= sw_value;
        press_key(input_pkg::key_toggle);
        press_key(input_pkg::key_enter);
        check_status("switch_mode status", 1'b1, 1'b1, 1'b0);
        check_data("switch_mode data", input_pkg::data_t'(sw_value));
        start_session();
        check_status("switch_mode cleared", 1'b0, 1'b0, 1'b0);
        repeat (2) enter_digit($unsigned($random(seed)) % 10);
        press_key(input_pkg::key_toggle);
        check_data("switch_mode second data", input_pkg::data_t'(sw_value));
        press_key(input_pkg::key_toggle);
        check_status("keypad_return status", 1'b0, 1'b0, 1'b0);
        check_data("keypad_return data", exp_value);
        press_key(input_pkg::key_enter);
        check_status("keypad_return complete", 1'b1, 1'b0, 1'b0);

        // pause and resume
        press_key(input_pkg::key_pause);
        expect_eq("pause pin", 32'd1, cpu_pause);
        check_status("pause status", 1'b1, 1'b0, 1'b1);
        press_key(input_pkg::key_pause);  // upload not done yet
        expect_eq("pause held pin", 32'd1, cpu_pause);
        @(posedge clk);
        upload_done <= 1'b1;
        press_key(input_pkg::key_pause);
        expect_eq("resume pin", 32'd0, cpu_pause);
        check_status("resume status", 1'b1, 1'b0, 1'b0);

        // unmapped offset
        apb_read(8'h0c, rd_data, rd_err);
        expect_eq("apb unmapped read pslverr", 32'd1, rd_err);
        apb_write(8'h0c, 32'd1, rd_err);
        expect_eq("apb unmapped write pslverr", 32'd1, rd_err);
        repeat (4) @(posedge clk);
        check_status("apb unmapped write ignored", 1'b1, 1'b0, 1'b0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/keypad_model.sv */
`default_nettype none
`timescale 1ns/1ps

module keypad_model (
    input  logic                 press,
    input  input_pkg::key_code_t key,
    input  logic [3:0]           col,
    output logic [3:0]           row
);

    logic [3:0] pos;  // {row index, column index} of the key on the board

    always_comb begin
        case (key)
            input_pkg::key_1:      pos = 4'h0;
            input_pkg::key_2:      pos = 4'h1;
            input_pkg::key_3:      pos = 4'h2;
            input_pkg::key_pause:  pos = 4'h3;
            input_pkg::key_4:      pos = 4'h4;
            input_pkg::key_5:      pos = 4'h5;
            input_pkg::key_6:      pos = 4'h6;
            input_pkg::key_toggle: pos = 4'h7;
            input_pkg::key_7:      pos = 4'h8;
            input_pkg::key_8:      pos = 4'h9;
            input_pkg::key_9:      pos = 4'ha;
            input_pkg::key_c:      pos = 4'hb;
            input_pkg::key_back:   pos = 4'hc;
            input_pkg::key_0:      pos = 4'hd;
            input_pkg::key_enter:  pos = 4'he;
            default:               pos = 4'hf;  // key d
        endcase
    end

    // a closed switch pulls its row low only while its column is driven low
    always_comb begin
        row = 4'hf;
        if (press && !col[pos[1:0]]) begin
            row[pos[3:2]] = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/input_top.sv */
`default_nettype none
`timescale 1ns/1ps

module input_top #(
    parameter int SCAN_DIV       = 4,
    parameter int DEBOUNCE_SCANS = 2,
    parameter int SWITCH_CNT     = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  input_pkg::reg_addr_t  paddr,
    input  input_pkg::data_t      pwdata,
    output input_pkg::data_t      prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [3:0]            col,
    input  logic [3:0]            row,
    input  logic [SWITCH_CNT-1:0] switches,
    input  logic                  upload_done,
    output logic                  cpu_pause,
    output logic                  overflow
);

    logic                  scan_step;
    logic                  key_valid;
    input_pkg::key_code_t  key_code;
    logic                  input_req;
    logic                  acc_clear;
    logic                  acc_push;
    logic                  acc_pop;
    logic [3:0]            push_digit;
    input_pkg::data_t      acc_value;
    input_pkg::digit_cnt_t digit_cnt;
    logic                  full;
    logic                  input_complete;
    logic                  switch_enable;

    assign overflow = full;  // led lights at the digit limit

    scan_timer #(.SCAN_DIV(SCAN_DIV)) timer0 (
        .clk(clk), .rst_n(rst_n), .scan_step(scan_step)
    );

    keypad_scan #(.DEBOUNCE_SCANS(DEBOUNCE_SCANS)) scan0 (
        .clk(clk), .rst_n(rst_n), .scan_step(scan_step), .row(row), .col(col),
        .key_valid(key_valid), .key_code(key_code)
    );

    digit_accum accum0 (
        .clk(clk), .rst_n(rst_n), .acc_clear(acc_clear), .acc_push(acc_push),
        .acc_pop(acc_pop), .push_digit(push_digit), .acc_value(acc_value),
        .digit_cnt(digit_cnt), .full(full)
    );

    input_fsm fsm0 (
        .clk(clk), .rst_n(rst_n), .key_valid(key_valid), .input_req(input_req),
        .upload_done(upload_done), .key_code(key_code), .acc_clear(acc_clear),
        .acc_push(acc_push), .acc_pop(acc_pop), .push_digit(push_digit),
        .input_complete(input_complete), .switch_enable(switch_enable), .cpu_pause(cpu_pause)
    );

    input_apb_regs #(.SWITCH_CNT(SWITCH_CNT)) regs0 (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .input_req(input_req), .input_complete(input_complete),
        .switch_enable(switch_enable), .cpu_pause(cpu_pause), .full(full),
        .digit_cnt(digit_cnt), .acc_value(acc_value), .switches(switches)
    );

endmodule

`default_nettype wire

/* hw/input_apb_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module input_apb_regs #(
    parameter int SWITCH_CNT = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  input_pkg::reg_addr_t  paddr,
    input  input_pkg::data_t      pwdata,
    output input_pkg::data_t      prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  input_req,
    input  logic                  input_complete,
    input  logic                  switch_enable,
    input  logic                  cpu_pause,
    input  logic                  full,
    input  input_pkg::digit_cnt_t digit_cnt,
    input  input_pkg::data_t      acc_value,
    input  logic [SWITCH_CNT-1:0] switches
);

    logic             access;  // apb access phase
    logic             mapped;
    input_pkg::data_t status_q;
    input_pkg::data_t data_q;

    assign access  = psel && penable;
    assign mapped  = (paddr == input_pkg::ctrl_addr) || (paddr == input_pkg::status_addr) ||
                     (paddr == input_pkg::data_addr);
    assign pready  = 1'b1;  // no wait states
    assign pslverr = access && !mapped;

    always_comb begin
        case (paddr)
            input_pkg::status_addr: prdata = status_q;
            input_pkg::data_addr:   prdata = data_q;
            default:                prdata = '0;  // ctrl reads back as zero
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            input_req <= 1'b0;
        end else begin
            input_req <= access && pwrite && (paddr == input_pkg::ctrl_addr) && pwdata[0];
        end
    end

    // snapshots of the live values, also resync the board switches
    always_ff @(posedge clk) begin
        status_q <= input_pkg::data_t'({digit_cnt, full, cpu_pause, switch_enable,
                                        input_complete});
        data_q   <= switch_enable ? input_pkg::data_t'(switches) : acc_value;
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel);

endmodule

`default_nettype wire

/* hw/input_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

module input_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 key_valid,
    input  logic                 input_req,
    input  logic                 upload_done,
    input  input_pkg::key_code_t key_code,
    output logic                 acc_clear,
    output logic                 acc_push,
    output logic                 acc_pop,
    output logic [3:0]           push_digit,
    output logic                 input_complete,
    output logic                 switch_enable,
    output logic                 cpu_pause
);

    input_pkg::input_state_t state;

    logic is_digit;

    assign is_digit = (key_code <= input_pkg::key_9);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= input_pkg::blocked;
            acc_clear      <= 1'b0;
            acc_push       <= 1'b0;
            acc_pop        <= 1'b0;
            push_digit     <= 4'd0;
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
            cpu_pause      <= 1'b0;
        end else begin
            acc_clear <= 1'b0;
            acc_push  <= 1'b0;
            acc_pop   <= 1'b0;
            case (state)
                input_pkg::blocked: begin
                    if (key_valid && key_code == input_pkg::key_pause) begin
                        state     <= input_pkg::halted;
                        cpu_pause <= 1'b1;
                    end else if (input_req) begin
                        state          <= input_pkg::keypad_mode;
                        acc_clear      <= 1'b1;
                        input_complete <= 1'b0;
                        switch_enable  <= 1'b0;  // held from a switch session until now
                    end
                end
                input_pkg::keypad_mode: begin
                    if (key_valid) begin
                        if (is_digit) begin
                            acc_push   <= 1'b1;
                            push_digit <= key_code;
                        end else begin
                            case (key_code)
                                input_pkg::key_back: acc_pop <= 1'b1;
                                input_pkg::key_toggle: begin
                                    state         <= input_pkg::switch_mode;
                                    switch_enable <= 1'b1;
                                end
                                input_pkg::key_enter: begin
                                    state          <= input_pkg::blocked;
                                    input_complete <= 1'b1;
                                end
                                input_pkg::key_pause: begin
                                    state          <= input_pkg::halted;
                                    input_complete <= 1'b1;
                                    cpu_pause      <= 1'b1;
                                end
                                default: ;  // keys c and d do nothing
                            endcase
                        end
                    end
                end
                input_pkg::switch_mode: begin
                    if (key_valid) begin
                        case (key_code)
                            input_pkg::key_toggle: begin
                                state         <= input_pkg::keypad_mode;
                                switch_enable <= 1'b0;
                            end
                            input_pkg::key_enter: begin
                                state          <= input_pkg::blocked;
                                input_complete <= 1'b1;
                            end
                            input_pkg::key_pause: begin
                                state          <= input_pkg::halted;
                                input_complete <= 1'b1;
                                cpu_pause      <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
                input_pkg::halted: begin
                    // resume needs the loader finished and a second pause
                    if (key_valid && key_code == input_pkg::key_pause && upload_done) begin
                        state     <= input_pkg::blocked;
                        cpu_pause <= 1'b0;
                    end
                end
                default: state <= input_pkg::blocked;
            endcase
        end
    end

    a_pause_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_pause == (state == input_pkg::halted));

endmodule

`default_nettype wire

/* hw/digit_accum.sv */
`default_nettype none
`timescale 1ns/1ps

module digit_accum (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  acc_clear,
    input  logic                  acc_push,
    input  logic                  acc_pop,
    input  logic [3:0]            push_digit,
    output input_pkg::data_t      acc_value,
    output input_pkg::digit_cnt_t digit_cnt,
    output logic                  full
);

    assign full = (digit_cnt == input_pkg::max_digits);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_value <= '0;
            digit_cnt <= '0;
        end else if (acc_clear) begin
            acc_value <= '0;
            digit_cnt <= '0;
        end else if (acc_push && !full) begin
            acc_value <= acc_value * 32'd10 + input_pkg::data_t'(push_digit);
            digit_cnt <= digit_cnt + 1'b1;
        end else if (acc_pop && (digit_cnt != '0)) begin
            acc_value <= acc_value / 32'd10;  // drops the last digit
            digit_cnt <= digit_cnt - 1'b1;
        end
    end

    a_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
        digit_cnt <= input_pkg::max_digits);

    // the fsm sends at most one edit per key
    a_no_push_pop: assert property (@(posedge clk) disable iff (!rst_n)
        !(acc_push && acc_pop));

endmodule

`default_nettype wire

/* hw/keypad_scan.sv */
`default_nettype none
`timescale 1ns/1ps

module keypad_scan #(
    parameter int DEBOUNCE_SCANS = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                scan_step,
    input  logic [3:0]          row,
    output logic [3:0]          col,
    output logic                key_valid,
    output input_pkg::key_code_t key_code
);

    localparam int CNT_W = $clog2(DEBOUNCE_SCANS + 1);

    logic             running;     // first step has driven a column
    logic [1:0]       col_idx;     // index of the low column
    logic             scan_any;    // some row seen low in this scan
    logic             scan_multi;  // more than one key in this scan
    logic [3:0]       scan_row;
    logic [1:0]       scan_col;
    logic [7:0]       last_snap;   // result of the previous full scan
    logic [CNT_W-1:0] stable_cnt;
    logic             reported;    // press already sent, wait for release

    logic             row_hit;
    logic             base_any;
    logic             base_multi;
    logic             new_any;
    logic             new_multi;
    logic [3:0]       new_row;
    logic [1:0]       new_col;
    logic [7:0]       snap;
    logic [CNT_W-1:0] next_cnt;
    logic             settled;

    // maps an active low row and a column index onto the 4x4 key layout
    function automatic input_pkg::key_code_t decode(input logic [3:0] r, input logic [1:0] c);
        logic [1:0] ridx;
        ridx = r[0] ? (r[1] ? (r[2] ? 2'd3 : 2'd2) : 2'd1) : 2'd0;
        case ({ridx, c})
            4'h0: decode = input_pkg::key_1;
            4'h1: decode = input_pkg::key_2;
            4'h2: decode = input_pkg::key_3;
            4'h3: decode = input_pkg::key_pause;
            4'h4: decode = input_pkg::key_4;
            4'h5: decode = input_pkg::key_5;
            4'h6: decode = input_pkg::key_6;
            4'h7: decode = input_pkg::key_toggle;
            4'h8: decode = input_pkg::key_7;
            4'h9: decode = input_pkg::key_8;
            4'ha: decode = input_pkg::key_9;
            4'hb: decode = input_pkg::key_c;
            4'hc: decode = input_pkg::key_back;
            4'hd: decode = input_pkg::key_0;
            4'he: decode = input_pkg::key_enter;
            4'hf: decode = input_pkg::key_d;
        endcase
    endfunction

    always_comb begin
        row_hit    = (row != 4'hf);
        base_any   = (col_idx != 2'd0) && scan_any;  // column 0 starts a fresh scan
        base_multi = (col_idx != 2'd0) && scan_multi;
        new_any    = base_any || row_hit;
        new_multi  = base_multi || (row_hit && (base_any || !$onehot(~row)));
        new_row    = (row_hit && !base_any) ? row : scan_row;
        new_col    = (row_hit && !base_any) ? col_idx : scan_col;
        snap       = {new_multi, new_any, (new_any && !new_multi) ? {new_row, new_col} : 6'd0};
        if (snap != last_snap) begin
            next_cnt = CNT_W'(1);
        end else if (stable_cnt < CNT_W'(DEBOUNCE_SCANS)) begin
            next_cnt = stable_cnt + 1'b1;
        end else begin
            next_cnt = stable_cnt;
        end
        settled    = (next_cnt >= CNT_W'(DEBOUNCE_SCANS));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col        <= 4'hf;
            running    <= 1'b0;
            col_idx    <= 2'd0;
            scan_any   <= 1'b0;
            scan_multi <= 1'b0;
            scan_row   <= 4'hf;
            scan_col   <= 2'd0;
            last_snap  <= 8'd0;
            stable_cnt <= '0;
            reported   <= 1'b0;
            key_valid  <= 1'b0;
            key_code   <= input_pkg::key_0;
        end else begin
            key_valid <= 1'b0;
            if (scan_step && !running) begin
                running <= 1'b1;
                col     <= 4'b1110;
            end else if (scan_step) begin
                col        <= {col[2:0], col[3]};  // next column low
                col_idx    <= col_idx + 2'd1;
                scan_any   <= new_any;
                scan_multi <= new_multi;
                scan_row   <= new_row;
                scan_col   <= new_col;
                if (col_idx == 2'd3) begin
                    last_snap  <= snap;
                    stable_cnt <= next_cnt;
                    if (settled && new_any && !new_multi && !reported) begin
                        key_valid <= 1'b1;
                        key_code  <= decode(new_row, new_col);
                        reported  <= 1'b1;
                    end else if (settled && !new_any) begin
                        reported  <= 1'b0;  // released long enough
                    end
                end
            end
        end
    end

    a_one_col_low: assert property (@(posedge clk) disable iff (!rst_n)
        running |-> $onehot(~col));

endmodule

`default_nettype wire

/* hw/scan_timer.sv */
`default_nettype none
`timescale 1ns/1ps

module scan_timer #(
    parameter int SCAN_DIV = 4
) (
    input  logic clk,
    input  logic rst_n,
    output logic scan_step
);

    localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    assign scan_step = (cnt == CNT_W'(SCAN_DIV - 1));  // one cycle per wrap

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (scan_step) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // with a real divider the step can never be a level
    a_step_is_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (SCAN_DIV > 1) && scan_step |=> !scan_step);

endmodule

`default_nettype wire

/* hw/input_pkg.sv */
`default_nettype none

package input_pkg;

    typedef logic [31:0] data_t;       // input value as the cpu reads it
    typedef logic [3:0]  digit_cnt_t;  // digits entered, 0 to 8
    typedef logic [7:0]  reg_addr_t;   // apb byte offset

    typedef enum logic [3:0] {
        key_0 = 4'd0, key_1, key_2, key_3, key_4,
        key_5, key_6, key_7, key_8, key_9,
        key_back,    // "*" deletes the last digit
        key_enter,   // "#" confirms the value
        key_pause,   // "A" halts and resumes the cpu
        key_toggle,  // "B" swaps keypad and switch entry
        key_c,
        key_d
    } key_code_t;

    typedef enum logic [1:0] {
        blocked     = 2'b00,
        switch_mode = 2'b01,
        keypad_mode = 2'b10,
        halted      = 2'b11
    } input_state_t;

    localparam reg_addr_t  ctrl_addr   = 8'h00;
    localparam reg_addr_t  status_addr = 8'h04;
    localparam reg_addr_t  data_addr   = 8'h08;

    localparam digit_cnt_t max_digits  = 4'd8;

endpackage

`default_nettype wire
